/* filelist.f */
logic/bdmaPkg.sv
logic/bdmaRegs.sv
logic/bdmaSequencer.sv
logic/bdmaReadPacker.sv
logic/bdmaWriteSlicer.sv
logic/bdmaTop.sv
dv/bdma_checker.sv
dv/bdmaTb.sv

/* Bender.yml */
package:
  name: bdma

sources:
  - logic/bdmaPkg.sv
  - logic/bdmaRegs.sv
  - logic/bdmaSequencer.sv
  - logic/bdmaReadPacker.sv
  - logic/bdmaWriteSlicer.sv
  - logic/bdmaTop.sv
  - target: simulation
    files:
      - dv/bdma_checker.sv
      - dv/bdmaTb.sv

/* dv/bdmaTb.sv */
`timescale 1ns/1ps

module bdmaTb import bdmaPkg::*; ();

  localparam logic [23:0] mulConst = 24'h9E3779;

  logic DSPCLK = 1'b0;
  logic RST = 1'b1;
  logic regWe = 1'b0;
  logic stealAck = 1'b0;
  bdmaRegSel_e regSel = selCount;
  logic [15:0] regWdata = '0;
  logic [15:0] regRdata;
  logic [21:0] extAddr;
  logic extRdN, extWrN, stealReq, intPm, intWe, busy, bdmaEnd, bootResetReq;
  logic [7:0] extRdata, extWdata;
  logic [13:0] intAddr;
  logic [23:0] intRdata;
  bdmaWord_u intWdata;
  bdmaType_e curType;
  logic [7:0] curPage;
  logic [13:0] curInt, curExt;
  logic [15:0] lfsr = 16'd38536;
  int curWait, wordIdx, wrByte, endCount, rdLen, wrLen;
  int errors = 0;
  int timeouts = 0;

  always #2 DSPCLK = ~DSPCLK;

  function automatic logic [7:0] extByte(logic [21:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic int bytesPerWord(bdmaType_e t);
    return (t == typePmWord) ? 3 : (t == typeDmFull) ? 2 : 1;
  endfunction

  function automatic logic [15:0] galoisStep(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  assign extRdata = extByte(extAddr);
  assign intRdata = 24'(intAddr * mulConst);

  bdmaTop DUT (.*);
  bind bdmaTop bdma_checker uChecker (.DSPCLK, .RST, .ctl, .stealReq, .stealAck, .intWe,
    .busy, .bdmaEnd, .bootResetReq);

  // ======================================================================
  // arbiter and bus monitors
  // ======================================================================
  initial begin : ackDriver
    int delay;
    forever begin
      @(posedge DSPCLK);
      if (!RST && stealReq && !stealAck) begin
        delay = 0;
        repeat (3) begin
          lfsr = galoisStep(lfsr);
          delay = delay * 2 + lfsr[0];
        end
        repeat (delay) @(posedge DSPCLK);
        stealAck <= 1'b1;
        @(posedge DSPCLK);
        stealAck <= 1'b0;
      end
    end
  end

  always @(posedge DSPCLK) begin : monitor
    logic [21:0] a;
    logic [23:0] w, exp;
    int nb;
    nb = bytesPerWord(curType);
    if (!RST && stealReq && stealAck) begin
      assert (intPm == (curType == typePmWord)) else begin
        errors++;
        $display("ERROR %0t: intPm is %b during a %s transfer", $time, intPm, curType.name());
      end
    end
    if (!RST && intWe) begin
      a = {curPage, 14'(curExt + wordIdx * nb)};
      case (curType)
        typePmWord: exp = {extByte(a), extByte(a + 1), extByte(a + 2)};
        typeDmFull: exp = {extByte(a), extByte(a + 1), 8'h00};
        typeDmHigh: exp = {extByte(a), 16'h0000};
        default:    exp = {8'h00, extByte(a), 8'h00};
      endcase
      assert (intAddr == 14'(curInt + wordIdx) &&
              (curType == typePmWord ? intWdata.pmWord == exp
                                     : intWdata.dm.dmWord == exp[23:8] &&
                                       intWdata.dm.unused == 8'h00)) else begin
        errors++;
        $display("ERROR %0t: word %0d got %h at %h, expected %h", $time, wordIdx,
                 intWdata.pmWord, intAddr, exp);
      end
      wordIdx++;
    end
    if (!extWrN) begin
      w = 24'(14'(curInt + wrByte / nb) * mulConst);
      case ((curType == typeDmLow) ? 1 : wrByte % nb)
        0:       exp[7:0] = w[23:16];
        1:       exp[7:0] = w[15:8];
        default: exp[7:0] = w[7:0];
      endcase
      assert (extWdata == exp[7:0] && extAddr == {curPage, 14'(curExt + wrByte)}) else begin
        errors++;
        $display("ERROR %0t: byte %0d wrote %h at %h, expected %h", $time, wrByte, extWdata,
                 extAddr, exp[7:0]);
      end
    end
    if (!extRdN) rdLen++;
    if (!extWrN) wrLen++;
    if ((extRdN && rdLen != 0) || (extWrN && wrLen != 0)) begin
      assert (rdLen + wrLen == curWait + 1) else begin
        errors++;
        $display("ERROR %0t: strobe lasted %0d cycles", $time, rdLen + wrLen);
      end
      if (wrLen != 0) wrByte++;
      rdLen = 0;
      wrLen = 0;
    end
    if (bdmaEnd) endCount++;
  end

  // ======================================================================
  // register access and transfers
  // ======================================================================
  task automatic writeReg(bdmaRegSel_e sel, logic [15:0] data);
    @(posedge DSPCLK);
    regWe <= 1'b1;
    regSel <= sel;
    regWdata <= data;
    @(posedge DSPCLK);
    regWe <= 1'b0;
  endtask

  task automatic checkReg(bdmaRegSel_e sel, logic [15:0] exp);
    @(posedge DSPCLK);
    regSel <= sel;
    @(posedge DSPCLK);
    assert (regRdata == exp) else begin
      errors++;
      $display("ERROR %0t: register %s reads %h, expected %h", $time, sel.name(), regRdata, exp);
    end
  endtask

  task automatic runXfer(bdmaType_e t, logic dir, logic [3:0] ws, logic boot,
                         logic [7:0] page, logic [13:0] intA, logic [13:0] extA, int words);
    int cycles;
    logic seen;
    curType = t;
    curPage = page;
    curInt = intA;
    curExt = extA;
    curWait = (ws == 0) ? 15 : ws;  // zero selects the longest wait
    wordIdx = 0;
    wrByte = 0;
    endCount = 0;
    writeReg(selCtl, {page, ws, boot, dir, t});
    checkReg(selCtl, {page, 4'(curWait), boot, dir, t});
    writeReg(selIntAddr, 16'(intA));
    writeReg(selExtAddr, 16'(extA));
    checkReg(selIntAddr, 16'(intA));
    checkReg(selExtAddr, 16'(extA));
    writeReg(selCount, 16'(words));
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < 4000) begin
      @(posedge DSPCLK);
      seen = bdmaEnd;
      cycles++;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: the transfer of type %s never raised bdmaEnd", t.name());
    end
    cycles = 0;
    while (busy && cycles < 20) begin
      @(posedge DSPCLK);
      cycles++;
    end
    if (busy) begin
      timeouts++;
      $display("timeout: busy stayed high after the end of the transfer");
    end
    checkReg(selCount, 16'h0000);
    checkReg(selIntAddr, 16'(14'(intA + words)));
    checkReg(selExtAddr, 16'(14'(extA + words * bytesPerWord(t))));
    assert (endCount == 1 && (dir || wordIdx == words)) else begin
      errors++;
      $display("ERROR %0t: %0d end pulses and %0d words seen", $time, endCount, wordIdx);
    end
  endtask

  initial begin
    curType = typePmWord;
    curWait = 15;
    rdLen = 0;
    wrLen = 0;
    repeat (16) @(posedge DSPCLK);
    RST <= 1'b0;
    runXfer(typePmWord, 1'b0, 4'd0, 1'b1, 8'h12, 14'h0100, 14'h00F0, 4);
    runXfer(typeDmFull, 1'b0, 4'd1, 1'b0, 8'h03, 14'h0200, 14'h0311, 5);
    runXfer(typeDmHigh, 1'b0, 4'd2, 1'b0, 8'h00, 14'h0300, 14'h0420, 3);
    runXfer(typeDmLow,  1'b0, 4'd3, 1'b0, 8'h45, 14'h0310, 14'h0505, 3);
    runXfer(typePmWord, 1'b1, 4'd1, 1'b1, 8'h01, 14'h0040, 14'h0600, 3);
    runXfer(typeDmFull, 1'b1, 4'd2, 1'b0, 8'h02, 14'h0050, 14'h0700, 2);
    runXfer(typeDmHigh, 1'b1, 4'd0, 1'b0, 8'h02, 14'h0060, 14'h0800, 2);
    runXfer(typeDmLow,  1'b1, 4'd1, 1'b0, 8'h02, 14'h0070, 14'h0900, 2);
    $display("errors %0d, checker errors %0d, timeouts %0d", errors,
             DUT.uChecker.errCount, timeouts);
    if (errors + DUT.uChecker.errCount + timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* dv/bdma_checker.sv */
`timescale 1ns/1ps

module bdma_checker import bdmaPkg::*; (
  input logic     DSPCLK,
  input logic     RST,
  input bdmaCtl_t ctl,
  input logic     stealReq,
  input logic     stealAck,
  input logic     intWe,
  input logic     busy,
  input logic     bdmaEnd,
  input logic     bootResetReq
);

  int errCount = 0;

  // a request is only withdrawn by a granted access
  reqHold: assert property (@(posedge DSPCLK) disable iff (RST)
    stealReq && !stealAck |=> stealReq)
    else begin
      errCount++;
      $error("stealReq fell without a stealAck cycle");
    end

  // internal writes happen on read direction grants and nowhere else
  weOnGrant: assert property (@(posedge DSPCLK) disable iff (RST)
    intWe == (stealReq && stealAck && !ctl.dir))
    else begin
      errCount++;
      $error("intWe does not match a read direction grant");
    end

  endThenIdle: assert property (@(posedge DSPCLK) disable iff (RST)
    bdmaEnd |=> !busy && !bdmaEnd)
    else begin
      errCount++;
      $error("busy or bdmaEnd still high after the end pulse");
    end

  bootTwoCycles: assert property (@(posedge DSPCLK) disable iff (RST)
    bdmaEnd && ctl.bootReset |-> bootResetReq ##1 bootResetReq ##1 !bootResetReq)
    else begin
      errCount++;
      $error("bootResetReq is not a two cycle pulse");
    end

endmodule

/* logic/bdmaTop.sv */
`timescale 1ns/1ps

module bdmaTop import bdmaPkg::*; (
  input  logic                    DSPCLK,
  input  logic                    RST,
  input  logic                    regWe,
  input  bdmaRegSel_e             regSel,
  input  logic [15:0]             regWdata,
  output logic [15:0]             regRdata,
  output logic [extAddrWidth-1:0] extAddr,
  output logic                    extRdN,
  output logic                    extWrN,
  input  logic [7:0]              extRdata,
  output logic [7:0]              extWdata,
  output logic                    stealReq,
  input  logic                    stealAck,
  output logic                    intPm,
  output logic [addrWidth-1:0]    intAddr,
  output logic                    intWe,
  output bdmaWord_u               intWdata,
  input  logic [23:0]             intRdata,
  output logic                    busy,
  output logic                    bdmaEnd,
  output logic                    bootResetReq
);

  bdmaCtl_t              ctl;
  logic                  start;
  logic [countWidth-1:0] count;
  logic [addrWidth-1:0]  intAddrReg;
  logic [addrWidth-1:0]  extAddrReg;
  logic                  wordDone;
  logic                  byteDone;
  logic                  byteStrobe;
  logic [1:0]            byteIndex;
  logic                  wordPending;

  assign intPm   = (ctl.xferType == typePmWord);
  assign intAddr = intAddrReg;

  bdmaRegs uRegs (
    .DSPCLK, .RST, .regWe, .regSel, .regWdata, .wordDone, .byteDone,
    .regRdata, .ctl, .start, .count, .intAddrReg, .extAddrReg
  );

  bdmaSequencer uSequencer (
    .DSPCLK, .RST, .ctl, .start, .count, .extAddrReg, .wordPending, .stealAck,
    .busy, .extAddr, .extRdN, .extWrN, .stealReq, .byteStrobe, .byteIndex,
    .wordDone, .byteDone, .bdmaEnd, .bootResetReq
  );

  bdmaReadPacker uReadPacker (
    .DSPCLK, .RST, .ctl, .byteStrobe, .byteIndex, .extRdata, .stealAck,
    .intWdata, .intWe, .wordPending
  );

  bdmaWriteSlicer uWriteSlicer (
    .DSPCLK, .RST, .ctl, .intRdata, .stealAck, .stealReq, .byteIndex, .extWdata
  );

endmodule

/* logic/bdmaWriteSlicer.sv */
`timescale 1ns/1ps

module bdmaWriteSlicer import bdmaPkg::*; (
  input  logic        DSPCLK,
  input  logic        RST,
  input  bdmaCtl_t    ctl,
  input  logic [23:0] intRdata,
  input  logic        stealAck,
  input  logic        stealReq,
  input  logic [1:0]  byteIndex,
  output logic [7:0]  extWdata
);

  logic [23:0] heldWord;

  // internal read data is only valid on the grant cycle
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST)
      heldWord <= '0;
    else if (ctl.dir && stealReq && stealAck)
      heldWord <= intRdata;
  end

  // ======================================================================
  // lane select, the packer's placement run backwards
  // ======================================================================
  always_comb begin
    case (laneOf(ctl.xferType, byteIndex))
      2'd0:    extWdata = heldWord[23:16];
      2'd1:    extWdata = heldWord[15:8];
      default: extWdata = heldWord[7:0];
    endcase
  end

endmodule

/* logic/bdmaReadPacker.sv */
`timescale 1ns/1ps

module bdmaReadPacker import bdmaPkg::*; (
  input  logic       DSPCLK,
  input  logic       RST,
  input  bdmaCtl_t   ctl,
  input  logic       byteStrobe,
  input  logic [1:0] byteIndex,
  input  logic [7:0] extRdata,
  input  logic       stealAck,
  output bdmaWord_u  intWdata,
  output logic       intWe,
  output logic       wordPending
);

  bdmaWord_u asmWord;
  bdmaWord_u nextWord;
  logic      wordComplete;

  assign wordComplete = byteStrobe && (byteIndex == lastIndex(ctl.xferType));

  // the incoming byte merged into the word under assembly
  always_comb begin
    nextWord = asmWord;
    case (laneOf(ctl.xferType, byteIndex))
      2'd0:    nextWord.pmWord[23:16] = extRdata;
      2'd1:    nextWord.pmWord[15:8]  = extRdata;
      default: nextWord.pmWord[7:0]   = extRdata;
    endcase
    if (ctl.xferType != typePmWord)
      nextWord.dm.unused = '0;
    if (ctl.xferType == typeDmHigh)
      nextWord.dm.dmWord[7:0] = '0;  // aligned high, zero below
    if (ctl.xferType == typeDmLow)
      nextWord.dm.dmWord[15:8] = '0;
  end

  always_ff @(posedge DSPCLK) begin
    if (byteStrobe)
      asmWord <= nextWord;
    if (wordComplete)
      intWdata <= nextWord; // holding register frees assembly for the next word
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST)
      wordPending <= 1'b0;
    else if (wordComplete)
      wordPending <= 1'b1;
    else if (stealAck)
      wordPending <= 1'b0;
  end

  assign intWe = wordPending && stealAck;

endmodule

/* logic/bdmaSequencer.sv */
`timescale 1ns/1ps

module bdmaSequencer import bdmaPkg::*; (
  input  logic                    DSPCLK,
  input  logic                    RST,
  input  bdmaCtl_t                ctl,
  input  logic                    start,
  input  logic [countWidth-1:0]   count,
  input  logic [addrWidth-1:0]    extAddrReg,
  input  logic                    wordPending,
  input  logic                    stealAck,
  output logic                    busy,
  output logic [extAddrWidth-1:0] extAddr,
  output logic                    extRdN,
  output logic                    extWrN,
  output logic                    stealReq,
  output logic                    byteStrobe,
  output logic [1:0]              byteIndex,
  output logic                    wordDone,
  output logic                    byteDone,
  output logic                    bdmaEnd,
  output logic                    bootResetReq
);

  logic       active;    // external strobe phase of a byte
  logic [3:0] waitCnt;
  logic [1:0] byteCnt;
  logic       haveWord;  // write direction word captured and being sliced
  logic       writeReq;
  logic       lastWord;
  logic       endDly;
  logic       lastWait;
  logic       finalByte;
  logic       grant;
  logic       readStart;
  logic       writeStart;

  assign lastWait  = active && (waitCnt == ctl.waitStates);
  assign finalByte = (byteCnt == lastIndex(ctl.xferType));
  assign grant     = stealReq && stealAck;

  // a new read word only starts while more words remain than already wait for a grant,
  // and a word's final byte waits until the holding register is free
  assign readStart = !ctl.dir && !active &&
                     (byteCnt != 2'd0 || count > countWidth'(wordPending)) &&
                     !(finalByte && wordPending && !stealAck);
  assign writeStart = ctl.dir && !active && (grant || (haveWord && byteCnt != 2'd0));

  // ======================================================================
  // byte timing
  // ======================================================================
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      active  <= 1'b0;
      waitCnt <= '0;
      byteCnt <= '0;
    end else begin
      if (start)
        busy <= 1'b1;
      else if (bdmaEnd)
        busy <= 1'b0;
      if (lastWait)
        active <= 1'b0;
      else if (busy && (readStart || writeStart))
        active <= 1'b1;
      if (lastWait)
        waitCnt <= '0;
      else if (active)
        waitCnt <= waitCnt + 1'b1;
      if (start)
        byteCnt <= '0;
      else if (lastWait)
        byteCnt <= finalByte ? 2'd0 : byteCnt + 1'b1;
    end
  end

  // ======================================================================
  // write direction steal and completion
  // ======================================================================
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      haveWord <= 1'b0;
      writeReq <= 1'b0;
      lastWord <= 1'b0;
      endDly   <= 1'b0;
    end else begin
      if (grant && ctl.dir)
        haveWord <= 1'b1;
      else if (lastWait && finalByte)
        haveWord <= 1'b0;
      if (grant)
        writeReq <= 1'b0;
      else if (busy && ctl.dir && !haveWord && !active && count != '0)
        writeReq <= 1'b1;
      if (grant && ctl.dir)
        lastWord <= (count == countWidth'(1));
      endDly <= bdmaEnd && ctl.bootReset; // second cycle of the core reset request
    end
  end

  assign stealReq = writeReq || wordPending;
  assign bdmaEnd  = busy && (ctl.dir ? (lastWait && finalByte && lastWord)
                                     : (grant && count == countWidth'(1)));
  assign bootResetReq = (bdmaEnd && ctl.bootReset) || endDly;

  assign byteStrobe = lastWait && !ctl.dir;
  assign byteDone   = lastWait;
  assign wordDone   = grant;
  assign byteIndex  = byteCnt;
  assign extAddr    = {ctl.page, extAddrReg};
  assign extRdN     = !(active && !ctl.dir);
  assign extWrN     = !(active && ctl.dir);

endmodule

/* logic/bdmaRegs.sv */
`timescale 1ns/1ps

module bdmaRegs import bdmaPkg::*; (
  input  logic                  DSPCLK,
  input  logic                  RST,
  input  logic                  regWe,
  input  bdmaRegSel_e           regSel,
  input  logic [15:0]           regWdata,
  input  logic                  wordDone,
  input  logic                  byteDone,
  output logic [15:0]           regRdata,
  output bdmaCtl_t              ctl,
  output logic                  start,
  output logic [countWidth-1:0] count,
  output logic [addrWidth-1:0]  intAddrReg,
  output logic [addrWidth-1:0]  extAddrReg
);

  bdmaCtl_t ctlWr;
  logic     wrCount;
  logic     wrCtl;
  logic     wrIntAddr;
  logic     wrExtAddr;

  assign wrCount   = regWe && (regSel == selCount);
  assign wrCtl     = regWe && (regSel == selCtl);
  assign wrIntAddr = regWe && (regSel == selIntAddr);
  assign wrExtAddr = regWe && (regSel == selExtAddr);

  assign start = wrCount && (regWdata[countWidth-1:0] != '0); // zero count never starts

  always_comb begin
    ctlWr = bdmaCtl_t'(regWdata);
    if (ctlWr.waitStates == 4'd0)
      ctlWr.waitStates = defaultWait;
  end

  // ======================================================================
  // software writes win over engine updates in the same cycle
  // ======================================================================
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      ctl   <= '{page: '0, waitStates: defaultWait, bootReset: 1'b0,
                 dir: 1'b0, xferType: typePmWord};
      count <= '0;
    end else begin
      if (wrCtl)
        ctl <= ctlWr;
      if (wrCount)
        count <= regWdata[countWidth-1:0];
      else if (wordDone)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      intAddrReg <= '0;
      extAddrReg <= '0;
    end else begin
      if (wrIntAddr)
        intAddrReg <= regWdata[addrWidth-1:0];
      else if (wordDone)
        intAddrReg <= intAddrReg + 1'b1; // one internal word per grant
      if (wrExtAddr)
        extAddrReg <= regWdata[addrWidth-1:0];
      else if (byteDone)
        extAddrReg <= extAddrReg + 1'b1;
    end
  end

  always_comb begin
    case (regSel)
      selCount:   regRdata = 16'(count);
      selCtl:     regRdata = 16'(ctl);
      selIntAddr: regRdata = 16'(intAddrReg);
      default:    regRdata = 16'(extAddrReg);
    endcase
  end

endmodule

/* logic/bdmaPkg.sv */
package bdmaPkg;

  localparam int addrWidth    = 14;
  localparam int countWidth   = 14;
  localparam int extAddrWidth = 22;

  // wait count used after reset and whenever software writes zero
  localparam logic [3:0] defaultWait = 4'd15;

  typedef enum logic [1:0] {
    selCount   = 2'd0,
    selCtl     = 2'd1,
    selIntAddr = 2'd2,
    selExtAddr = 2'd3
  } bdmaRegSel_e;

  typedef enum logic [1:0] {
    typePmWord = 2'd0,  // three bytes, high first
    typeDmFull = 2'd1,  // two bytes, high first
    typeDmHigh = 2'd2,  // one byte in the high half, low half zero
    typeDmLow  = 2'd3   // one byte in the low half, high half zero
  } bdmaType_e;

  typedef struct packed {
    logic [7:0] page;
    logic [3:0] waitStates;
    logic       bootReset;
    logic       dir;        // 1 moves internal words out to the external bus
    bdmaType_e  xferType;
  } bdmaCtl_t;

  typedef struct packed {
    logic [15:0] dmWord;
    logic [7:0]  unused;
  } bdmaDmWord_t;

  typedef union packed {
    logic [23:0] pmWord;
    bdmaDmWord_t dm;
  } bdmaWord_u;

  // index of the final byte of a word for each transfer type
  function automatic logic [1:0] lastIndex(bdmaType_e xferType);
    case (xferType)
      typePmWord: return 2'd2;
      typeDmFull: return 2'd1;
      default:    return 2'd0;
    endcase
  endfunction

  // lane 0 is bits 23:16, lane 1 is 15:8, lane 2 is 7:0
  function automatic logic [1:0] laneOf(bdmaType_e xferType, logic [1:0] byteIndex);
    return (xferType == typeDmLow) ? 2'd1 : byteIndex;
  endfunction

endpackage
